// File: hw/ccc_config.svh
// ----------------------------------------------------------------------
// CCC engine configuration macros
// register file locations, DDR word bit positions, DAT base address
// and the error hold time
// ----------------------------------------------------------------------
`ifndef CCC_CONFIG_SVH
`define CCC_CONFIG_SVH

// register file map
`define CCC_REGF_BASE          16'd1000                    // first descriptor location
`define CCC_REGF_ZERO_LOC      (`CCC_REGF_BASE - 16'd1)    // eight zero bits live here
`define CCC_REGF_DEFBYTE_LOC   (`CCC_REGF_BASE + 16'd2)    // defining byte
`define CCC_REGF_REG_DATA_OFS  16'd4                       // regular descriptor data start
`define CCC_REGF_IMM_DATA_OFS  16'd2                       // immediate, +1 with defining byte

// end bit counts inside a 20 bit DDR word, counter wraps after 19
`define CCC_BIT_PRE_END        6'd2
`define CCC_BIT_RNW_END        6'd3
`define CCC_BIT_RSV_END        6'd10
`define CCC_BIT_BYTE1_END      6'd10
`define CCC_BIT_BYTE2_END      6'd18
`define CCC_BIT_PAR_END        6'd0

// crc word layout
`define CCC_BIT_CRC_TOKEN_END  6'd6     // 4'hC token below this
`define CCC_BIT_CRC_VALUE_END  6'd11    // 5 bit checksum below this
`define CCC_BIT_CRC_END        6'd12

// addressing
`define CCC_DAT_BASE_ADDR      7'd8     // device index 0
`define CCC_BCAST_ADDR         7'h7E

`define CCC_ERR_HOLD_CYCLES    6'd38    // ones driven in ERROR

`endif

// File: hw/ccc_pkg.sv
// ----------------------------------------------------------------------
// shared types of the CCC engine
// FSM states, tx/rx/stall codes, error codes, descriptor and port structs
// ----------------------------------------------------------------------
package ccc_pkg;

  typedef enum logic [4:0] {
    ST_IDLE, ST_PRE_CMD, ST_RNW, ST_RESERVED, ST_SECOND_CMD_BYTE,
    ST_PARITY_CMD, ST_PRE_FIRST_DATA, ST_CCC_BYTE, ST_DEFINING_BYTE,
    ST_ZEROS, ST_PARITY_DATA, ST_PRE_DATA, ST_FIRST_DATA_BYTE,
    ST_SECOND_DATA_BYTE, ST_CRC, ST_RESTART_PATTERN, ST_EXIT_PATTERN,
    ST_ERROR, ST_FINISH
  } ccc_state_e;

  typedef enum logic [3:0] {
    TX_ZERO       = 4'd0,  TX_ONE       = 4'd1,
    TX_SPECIAL_PRE = 4'd2, TX_SEVEN_ZEROS = 4'd3,  // 01 preamble, 7 reserved zeros
    TX_SER_ADDR   = 4'd5,  TX_SER_BYTE  = 4'd6,    // byte given by the engine
    TX_SER_FIRST  = 4'd7,  TX_SER_SECOND = 4'd8,   // bytes from the register file
    TX_PARITY     = 4'd9,  TX_CRC_TOKEN = 4'd10,
    TX_CRC_VALUE  = 4'd11, TX_RESTART   = 4'd12,
    TX_EXIT       = 4'd13
  } ccc_tx_mode_e;

  typedef enum logic [2:0] {RX_SECOND_PRE = 3'd0, RX_FIRST_PRE = 3'd1} ccc_rx_mode_e;

  typedef enum logic [3:0] {STALL_EXIT = 4'b1110, STALL_RESTART = 4'b1111} ccc_stall_code_e;

  typedef enum logic [3:0] {
    SUCCESS, CRC_ERR, PARITY_ERR, FRAME, ADDR_HEADER,
    NACK, OVL, SRE, C_ABORTED, T_ABORTED
  } ccc_err_e;

  // last descriptor nibble, view picked by attr[0]
  typedef union packed {
    struct packed {logic dbp; logic [2:0] pad;} regular;
    struct packed {logic [2:0] dtt; logic pad;} immediate;
  } ccc_descr_tail_u;

  typedef struct packed {
    logic [2:0]      attr;       // 0 regular, 1 immediate
    logic [7:0]      cmd;        // CCC value
    logic [4:0]      dev_index;  // DAT entry
    logic            toc;        // exit after this command
    ccc_descr_tail_u tail;
  } ccc_descr_t;

  typedef struct packed {
    logic [5:0] bitcnt;
    logic       tx_done;
    logic       rx_done;
    logic       rx_second_pre;  // sampled target preamble bit
    logic       stall_done;
    logic       last_frame;
  } ccc_phy_status_t;

  typedef struct packed {logic en; ccc_tx_mode_e    mode;} ccc_tx_ctrl_t;
  typedef struct packed {logic en; ccc_rx_mode_e    mode;} ccc_rx_ctrl_t;
  typedef struct packed {logic en; ccc_stall_code_e code;} ccc_stall_ctrl_t;

endpackage

// File: hw/ccc_cmd_decode.sv
// ----------------------------------------------------------------------
// CCC descriptor decode
// direct/broadcast flag, defining byte flag, target address from DAT
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "ccc_config.svh"

module ccc_cmd_decode
  import ccc_pkg::*;
(
  input  ccc_descr_t i_descr,
  output logic       o_direct,       // 1 direct, 0 broadcast
  output logic       o_def_byte,     // defining byte present
  output logic [6:0] o_target_addr
);

  // direct codes: ENEC, DISEC, SETMWL, SETMRL, GETMWL, GETMRL, GETSTATUS, RSTACT
  // everything else goes out as broadcast
  always_comb begin
    o_direct = i_descr.cmd inside {8'h80, 8'h81, 8'h89, 8'h8A,
                                   8'h8B, 8'h8C, 8'h90, 8'h9A};
  end

  always_comb begin
    if (i_descr.attr[0]) begin
      // immediate, dtt 5..7 means a defining byte sits in byte 3
      o_def_byte = (i_descr.tail.immediate.dtt >= 3'd5);
    end else begin
      o_def_byte = i_descr.tail.regular.dbp;  // regular, explicit flag
    end
  end

  // DAT is a plain linear map, index 0 -> address 8
  assign o_target_addr = `CCC_DAT_BASE_ADDR + {2'b00, i_descr.dev_index};

  // only regular and immediate descriptors reach this engine,
  // so attr[0] alone has to pick the tail view
  always_comb begin
    if (!$isunknown(i_descr.attr)) begin
      a_tail_view_sel : assert (i_descr.attr[2:1] == 2'b00)
        else $error("descriptor attr %0h not regular or immediate", i_descr.attr);
    end
  end

endmodule

// File: hw/ccc_regf_addr_gen.sv
// ----------------------------------------------------------------------
// register file data address counter
// loads the first data location, steps once per data byte
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "ccc_config.svh"

module ccc_regf_addr_gen
  import ccc_pkg::*;
(
  input  logic        i_sys_clk,
  input  logic        i_sys_rst,
  input  logic        i_load,        // transfer start
  input  logic        i_step,        // data byte sent
  input  logic        i_immediate,   // descriptor attr[0]
  input  logic        i_def_byte,
  output logic [15:0] o_data_addr
);

  logic [15:0] start_ofs;
  logic [15:0] data_addr_q;

  // immediate data shifts by one slot when the defining byte takes byte 3
  always_comb begin
    if (i_immediate) begin
      start_ofs = `CCC_REGF_IMM_DATA_OFS + {15'd0, i_def_byte};
    end else begin
      start_ofs = `CCC_REGF_REG_DATA_OFS;
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      data_addr_q <= `CCC_REGF_BASE;
    end else if (i_load) begin
      data_addr_q <= `CCC_REGF_BASE + start_ofs;
    end else if (i_step) begin
      data_addr_q <= data_addr_q + 16'd1;  // next byte location
    end
  end

  assign o_data_addr = data_addr_q;

  // the FSM loads only from IDLE and steps only in the data states
  a_load_step_excl : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    !(i_load && i_step))
    else $error("address load and step in the same cycle");

endmodule

// File: hw/ccc_engine_fsm.sv
// ----------------------------------------------------------------------
// CCC transfer state machine
// command word, CCC word, data words, CRC word, restart/exit patterns,
// error state with its own hold counter
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "ccc_config.svh"

module ccc_engine_fsm
  import ccc_pkg::*;
(
  input  logic            i_sys_clk,
  input  logic            i_sys_rst,
  input  logic            i_engine_en,
  input  ccc_phy_status_t i_phy,
  input  ccc_descr_t      i_descr,
  input  logic            i_direct,
  input  logic            i_def_byte,
  input  logic [6:0]      i_target_addr,
  input  logic [15:0]     i_data_addr,
  output logic            o_load,
  output logic            o_step,
  output ccc_tx_ctrl_t    o_tx,
  output logic [7:0]      o_txrx_addr_ccc,
  output ccc_rx_ctrl_t    o_rx,
  output ccc_stall_ctrl_t o_stall,
  output logic            o_bitcnt_en,
  output logic            o_frmcnt_en,
  output logic            o_regf_rd_en,
  output logic [15:0]     o_regf_addr,
  output logic            o_engine_done,
  output logic            o_engine_odd,
  output ccc_err_e        o_err_status
);

  ccc_state_e state_q, state_d;
  ccc_err_e   err_q, err_d;
  logic       first_frame_q;   // still in the 7E frame
  logic       odd_q;
  logic [5:0] hold_cnt_q;
  logic [5:0] bitcnt;
  logic       tx_done;
  logic       bcast_frame;     // 7E frame in front of a direct CCC
  logic       pre_rx;          // target owns the second preamble bit
  logic       pre_end;

  assign bitcnt      = i_phy.bitcnt;
  assign tx_done     = i_phy.tx_done;
  assign bcast_frame = i_direct && first_frame_q;
  assign pre_rx      = (bitcnt == `CCC_BIT_PRE_END - 6'd1 && tx_done) ||
                       (bitcnt == `CCC_BIT_PRE_END);
  assign pre_end     = (bitcnt == `CCC_BIT_PRE_END) && i_phy.rx_done;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      state_q       <= ST_IDLE;
      err_q         <= SUCCESS;
      first_frame_q <= 1'b1;
      odd_q         <= 1'b0;
      hold_cnt_q    <= 6'd0;
    end else begin
      state_q    <= state_d;
      err_q      <= err_d;
      hold_cnt_q <= (state_q == ST_ERROR) ? hold_cnt_q + 6'd1 : 6'd0;
      if (state_q == ST_IDLE && i_engine_en) begin
        first_frame_q <= 1'b1;
        odd_q         <= 1'b0;
      end else if (state_q == ST_RESTART_PATTERN && state_d == ST_PRE_CMD) begin
        first_frame_q <= 1'b0;  // target frame follows
      end
      if (state_q == ST_FIRST_DATA_BYTE && state_d == ST_ZEROS) begin
        odd_q <= 1'b1;
      end
    end
  end

  // odd shows already during the last single data byte
  assign o_engine_odd = odd_q || (state_q == ST_FIRST_DATA_BYTE && i_phy.last_frame);
  assign o_err_status = err_q;

  always_comb begin
    state_d         = state_q;
    err_d           = err_q;
    o_load          = 1'b0;
    o_step          = 1'b0;
    o_tx.en         = 1'b0;
    o_tx.mode       = TX_ZERO;
    o_txrx_addr_ccc = 8'h00;
    o_rx.en         = 1'b0;
    o_rx.mode       = RX_SECOND_PRE;
    o_stall.en      = 1'b0;
    o_stall.code    = STALL_EXIT;
    o_bitcnt_en     = 1'b1;   // low only outside the words
    o_frmcnt_en     = 1'b0;
    o_regf_rd_en    = 1'b0;
    o_regf_addr     = 16'd0;
    o_engine_done   = 1'b0;
    case (state_q)
      ST_IDLE: begin
        o_bitcnt_en = 1'b0;
        if (i_engine_en) begin
          o_load  = 1'b1;          // first data location
          err_d   = SUCCESS;
          state_d = ST_PRE_CMD;
        end
      end
      ST_PRE_CMD: begin
        o_tx = '{en: 1'b1, mode: TX_SPECIAL_PRE};
        if (bitcnt == `CCC_BIT_PRE_END && tx_done) state_d = ST_RNW;
      end
      ST_RNW: begin
        o_tx = '{en: 1'b1, mode: TX_ZERO};  // write only
        if (bitcnt == `CCC_BIT_RNW_END && tx_done) state_d = ST_RESERVED;
      end
      ST_RESERVED: begin
        o_tx = '{en: 1'b1, mode: TX_SEVEN_ZEROS};
        if (bitcnt == `CCC_BIT_RSV_END && tx_done) state_d = ST_SECOND_CMD_BYTE;
      end
      ST_SECOND_CMD_BYTE: begin
        // the first frame always goes to 7E, only a direct target frame carries the address
        o_tx            = '{en: 1'b1, mode: TX_SER_ADDR};
        o_txrx_addr_ccc = {1'b0, first_frame_q ? `CCC_BCAST_ADDR : i_target_addr};
        if (bitcnt == `CCC_BIT_BYTE2_END && tx_done) state_d = ST_PARITY_CMD;
      end
      ST_PARITY_CMD: begin
        o_tx = '{en: 1'b1, mode: TX_PARITY};
        if (bitcnt == `CCC_BIT_PAR_END && tx_done) begin
          // target frame of a direct CCC goes straight to its data
          state_d = (i_direct && !first_frame_q) ? ST_PRE_DATA : ST_PRE_FIRST_DATA;
        end
      end
      ST_PRE_FIRST_DATA, ST_PRE_DATA: begin
        if (pre_rx) begin
          o_rx = '{en: 1'b1, mode: RX_SECOND_PRE};
        end else begin
          o_tx = '{en: 1'b1, mode: TX_ONE};
        end
        if (pre_end && state_q == ST_PRE_FIRST_DATA) begin
          state_d = i_phy.rx_second_pre ? ST_ERROR : ST_CCC_BYTE;   // 1 is NACK
          err_d   = i_phy.rx_second_pre ? NACK : err_q;
        end else if (pre_end) begin
          state_d = i_phy.rx_second_pre ? ST_FIRST_DATA_BYTE : ST_ERROR;  // 0 is abort
          err_d   = i_phy.rx_second_pre ? err_q : T_ABORTED;
        end
      end
      ST_CCC_BYTE: begin
        o_tx            = '{en: 1'b1, mode: TX_SER_BYTE};
        o_txrx_addr_ccc = i_descr.cmd;
        if (bitcnt == `CCC_BIT_BYTE1_END && tx_done) begin
          state_d = i_def_byte ? ST_DEFINING_BYTE : ST_ZEROS;
        end
      end
      ST_DEFINING_BYTE, ST_ZEROS: begin
        o_tx         = '{en: 1'b1, mode: TX_SER_BYTE};
        o_regf_rd_en = 1'b1;
        o_regf_addr  = (state_q == ST_ZEROS) ? `CCC_REGF_ZERO_LOC : `CCC_REGF_DEFBYTE_LOC;
        if (bitcnt == `CCC_BIT_BYTE2_END && tx_done) state_d = ST_PARITY_DATA;
      end
      ST_PARITY_DATA: begin
        o_tx = '{en: 1'b1, mode: TX_PARITY};
        if (bitcnt == `CCC_BIT_PAR_END && tx_done) begin
          state_d = (i_phy.last_frame || bcast_frame) ? ST_CRC : ST_PRE_DATA;
        end
      end
      ST_FIRST_DATA_BYTE: begin
        o_tx         = '{en: 1'b1, mode: TX_SER_FIRST};
        o_regf_rd_en = 1'b1;
        o_regf_addr  = i_data_addr;
        if (bitcnt == `CCC_BIT_BYTE1_END && tx_done) begin
          o_frmcnt_en = 1'b1;
          o_step      = !i_phy.last_frame;
          state_d     = i_phy.last_frame ? ST_ZEROS : ST_SECOND_DATA_BYTE;  // odd count pads
        end
      end
      ST_SECOND_DATA_BYTE: begin
        o_tx         = '{en: 1'b1, mode: TX_SER_SECOND};
        o_regf_rd_en = 1'b1;
        o_regf_addr  = i_data_addr;
        if (bitcnt == `CCC_BIT_BYTE2_END && tx_done) begin
          o_frmcnt_en = 1'b1;
          o_step      = 1'b1;
          state_d     = ST_PARITY_DATA;
        end
      end
      ST_CRC: begin
        o_tx.en = 1'b1;
        if (bitcnt < `CCC_BIT_PRE_END) o_tx.mode = TX_SPECIAL_PRE;
        else if (bitcnt < `CCC_BIT_CRC_TOKEN_END) o_tx.mode = TX_CRC_TOKEN;
        else if (bitcnt < `CCC_BIT_CRC_VALUE_END) o_tx.mode = TX_CRC_VALUE;
        else o_tx.mode = TX_ONE;
        if (bitcnt == `CCC_BIT_CRC_END && tx_done) begin
          state_d = (bcast_frame || !i_descr.toc) ? ST_RESTART_PATTERN : ST_EXIT_PATTERN;
        end
      end
      ST_RESTART_PATTERN: begin
        o_bitcnt_en = 1'b0;  // next frame counts from 0
        o_tx        = '{en: 1'b1, mode: TX_RESTART};
        o_stall     = '{en: 1'b1, code: STALL_RESTART};
        if (i_phy.stall_done && tx_done) state_d = bcast_frame ? ST_PRE_CMD : ST_FINISH;
      end
      ST_EXIT_PATTERN: begin
        o_bitcnt_en = 1'b0;
        o_tx        = '{en: 1'b1, mode: TX_EXIT};
        o_stall     = '{en: 1'b1, code: STALL_EXIT};
        if (i_phy.stall_done && tx_done) state_d = ST_FINISH;
      end
      ST_ERROR: begin
        o_bitcnt_en = 1'b0;
        o_tx        = '{en: 1'b1, mode: TX_ONE};  // hold SDA high
        if (hold_cnt_q == `CCC_ERR_HOLD_CYCLES - 6'd1) state_d = ST_EXIT_PATTERN;
      end
      ST_FINISH: begin
        o_bitcnt_en   = 1'b0;
        o_engine_done = 1'b1;
        state_d       = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // the register file keeps the descriptor until the engine is idle again
  a_descr_stable : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    (state_q != ST_IDLE) |-> $stable(i_descr))
    else $error("descriptor changed during a transfer");

endmodule

// File: hw/ccc_handler.sv
// ----------------------------------------------------------------------
// CCC handler top level
// descriptor decode, data address counter and transfer FSM
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module ccc_handler
  import ccc_pkg::*;
(
  input  logic            i_sys_clk,
  input  logic            i_sys_rst,
  input  logic            i_engine_en,
  input  ccc_descr_t      i_descr,         // stable for the whole transfer
  input  ccc_phy_status_t i_phy,
  output ccc_tx_ctrl_t    o_tx,
  output logic [7:0]      o_txrx_addr_ccc,
  output ccc_rx_ctrl_t    o_rx,
  output ccc_stall_ctrl_t o_stall,
  output logic            o_bitcnt_en,
  output logic            o_frmcnt_en,
  output logic            o_regf_rd_en,
  output logic [15:0]     o_regf_addr,
  output logic            o_engine_done,
  output logic            o_engine_odd,
  output ccc_err_e        o_err_status
);

  logic        direct;
  logic        def_byte;
  logic [6:0]  target_addr;
  logic [15:0] data_addr;
  logic        addr_load;
  logic        addr_step;

  ccc_cmd_decode u_decode (
    .i_descr      (i_descr),
    .o_direct     (direct),
    .o_def_byte   (def_byte),
    .o_target_addr(target_addr)
  );

  ccc_regf_addr_gen u_addr_gen (
    .i_sys_clk  (i_sys_clk),
    .i_sys_rst  (i_sys_rst),
    .i_load     (addr_load),
    .i_step     (addr_step),
    .i_immediate(i_descr.attr[0]),
    .i_def_byte (def_byte),
    .o_data_addr(data_addr)
  );

  ccc_engine_fsm u_fsm (
    .i_sys_clk      (i_sys_clk),
    .i_sys_rst      (i_sys_rst),
    .i_engine_en    (i_engine_en),
    .i_phy          (i_phy),
    .i_descr        (i_descr),
    .i_direct       (direct),
    .i_def_byte     (def_byte),
    .i_target_addr  (target_addr),
    .i_data_addr    (data_addr),
    .o_load         (addr_load),
    .o_step         (addr_step),
    .o_tx           (o_tx),
    .o_txrx_addr_ccc(o_txrx_addr_ccc),
    .o_rx           (o_rx),
    .o_stall        (o_stall),
    .o_bitcnt_en    (o_bitcnt_en),
    .o_frmcnt_en    (o_frmcnt_en),
    .o_regf_rd_en   (o_regf_rd_en),
    .o_regf_addr    (o_regf_addr),
    .o_engine_done  (o_engine_done),
    .o_engine_odd   (o_engine_odd),
    .o_err_status   (o_err_status)
  );

endmodule

// File: tb/tb_clk_gen.sv
// ----------------------------------------------------------------------
// testbench clock and reset generator
// 8 ns clock, active low reset held for RST_CYCLES rising edges
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int RST_CYCLES = 5
) (
  output logic o_sys_clk,
  output logic o_sys_rst
);

  initial begin
    o_sys_clk = 1'b0;
    forever #4 o_sys_clk = ~o_sys_clk;  // 125 MHz
  end

  initial begin
    o_sys_rst = 1'b0;
    repeat (RST_CYCLES) @(posedge o_sys_clk);
    o_sys_rst <= 1'b1;  // release on a rising edge
  end

endmodule

// File: tb/tb_ccc_handler.sv
// ----------------------------------------------------------------------
// testbench for the CCC handler
// bus side responder model, table of CCC transfers, checkers
// and a per test report with a closing summary
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_ccc_handler
  import ccc_pkg::*;
();

  localparam int          NUM_ROWS    = 8;
  localparam int          WAIT_CYCLES = 600;      // per transfer including the error hold
  localparam logic [15:0] ZERO_LOC    = 16'd999;  // padding source

  typedef struct packed {
    logic [7:0]  cmd;
    logic [2:0]  attr;
    logic [4:0]  dev_index;
    logic [2:0]  dsel;            // dbp in bit 0 or dtt
    logic        toc;
    logic [3:0]  nbytes;          // at most 4 data bytes
    logic        nack;            // target NACKs the 7E header
    logic        abort;           // target aborts at the first data preamble
    ccc_err_e    exp_err;
    logic        exp_odd;
    logic        exp_exit;        // exit pattern last when set
    logic [6:0]  exp_target;      // 0 on a broadcast
    logic [15:0] exp_first_rd;    // zero or defining byte location
    logic [15:0] exp_data_start;
  } test_row_t;

  logic            sys_clk;
  logic            sys_rst;
  logic            engine_en;
  ccc_descr_t      descr;
  ccc_phy_status_t phy = '0;
  ccc_tx_ctrl_t    tx;
  logic [7:0]      addr_ccc;
  ccc_rx_ctrl_t    rx;
  ccc_stall_ctrl_t stall;
  logic            bitcnt_en;
  logic            frmcnt_en;
  logic            regf_rd_en;
  logic [15:0]     regf_addr;
  logic            engine_done;
  logic            engine_odd;
  ccc_err_e        err_status;

  test_row_t       rows [NUM_ROWS];
  test_row_t       cur = '0;           // row the responder plays
  int              cur_test = 0;
  int              err_cnt = 0;
  logic            timed_out = 1'b0;

  // responder state
  logic [3:0]      sent_cnt = '0;      // data bytes sent in this transfer
  logic [2:0]      stall_cnt = '0;
  logic [6:0]      frame_addr = '0;    // header address of the current frame
  logic [1:0]      pre_no = '0;        // preambles seen since that header

  // monitor state
  logic [6:0]      addr_q [$];
  logic [15:0]     rd_q [$];
  logic            rd_prev = 1'b0;
  logic [15:0]     rd_addr_prev = '0;
  logic            odd_seen = 1'b0;
  ccc_stall_code_e last_code = STALL_EXIT;
  int              done_cnt = 0;

  tb_clk_gen u_clk_gen (.o_sys_clk(sys_clk), .o_sys_rst(sys_rst));

  ccc_handler ccc_handler_i (
    .i_sys_clk      (sys_clk),
    .i_sys_rst      (sys_rst),
    .i_engine_en    (engine_en),
    .i_descr        (descr),
    .i_phy          (phy),
    .o_tx           (tx),
    .o_txrx_addr_ccc(addr_ccc),
    .o_rx           (rx),
    .o_stall        (stall),
    .o_bitcnt_en    (bitcnt_en),
    .o_frmcnt_en    (frmcnt_en),
    .o_regf_rd_en   (regf_rd_en),
    .o_regf_addr    (regf_addr),
    .o_engine_done  (engine_done),
    .o_engine_odd   (engine_odd),
    .o_err_status   (err_status)
  );

  // bus side model with done strobes tied high
  always @(posedge sys_clk) begin : responder
    logic [3:0] sent_n;
    sent_n = engine_en ? 4'd0 : sent_cnt + {3'd0, frmcnt_en};
    sent_cnt <= sent_n;
    phy.tx_done <= 1'b1;
    phy.rx_done <= 1'b1;
    if (!bitcnt_en || phy.bitcnt == 6'd19) phy.bitcnt <= 6'd0;  // 20 bit word
    else phy.bitcnt <= phy.bitcnt + 6'd1;
    stall_cnt <= !stall.en ? 3'd0 : (stall_cnt < 3'd3) ? stall_cnt + 3'd1 : stall_cnt;
    phy.stall_done <= stall.en && (stall_cnt >= 3'd2);          // 3 cycles after enable
    // last word once the bytes run out
    // a first byte can be the last one alone
    if (tx.en && tx.mode == TX_SER_FIRST) phy.last_frame <= (sent_n + 4'd1 >= cur.nbytes);
    else phy.last_frame <= (sent_n >= cur.nbytes);
    if (tx.en && tx.mode == TX_SER_ADDR) begin
      frame_addr <= addr_ccc[6:0];
      pre_no     <= 2'd0;
    end else if (rx.en && phy.bitcnt == 6'd2) begin
      pre_no <= pre_no + 2'd1;  // preamble sampled
    end
    if (frame_addr == 7'h7E && pre_no == 2'd0) phy.rx_second_pre <= cur.nack;  // ack slot
    else if (pre_no == ((frame_addr == 7'h7E) ? 2'd1 : 2'd0)) phy.rx_second_pre <= !cur.abort;
    else phy.rx_second_pre <= 1'b1;  // data continues
  end

  // collects header addresses, register reads, odd flag and pattern
  always @(posedge sys_clk) begin : monitor
    if (engine_en) begin
      addr_q.delete();
      rd_q.delete();
      odd_seen  = 1'b0;
      done_cnt  = 0;
      last_code = cur.exp_exit ? STALL_RESTART : STALL_EXIT;  // opposite of expected
    end
    if (tx.en && tx.mode == TX_SER_ADDR && phy.bitcnt == 6'd18) addr_q.push_back(addr_ccc[6:0]);
    if (regf_rd_en && (!rd_prev || regf_addr != rd_addr_prev)) rd_q.push_back(regf_addr);
    rd_prev      = regf_rd_en;
    rd_addr_prev = regf_addr;
    if (frmcnt_en) odd_seen = engine_odd;  // ends at the last data byte
    if (stall.en) last_code = stall.code;
    if (engine_done) done_cnt++;
  end

  function automatic ccc_descr_t make_descr(input test_row_t row);
    ccc_descr_t d;
    d           = '0;
    d.attr      = row.attr;
    d.cmd       = row.cmd;
    d.dev_index = row.dev_index;
    d.toc       = row.toc;
    if (row.attr[0]) d.tail.immediate.dtt = row.dsel;
    else d.tail.regular.dbp = row.dsel[0];
    return d;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH test %0d %s: got %h expected %h", cur_test, name, got, exp);
    err_cnt++;
  endtask

  task automatic run_row(input int idx);
    test_row_t   row;
    logic [15:0] exp_rd [$];
    int          cyc;
    int          errs_before;
    int          n_addr;
    row         = rows[idx];
    errs_before = err_cnt;
    cur_test    = idx + 1;
    if (!row.nack) exp_rd.push_back(row.exp_first_rd);  // CCC word second byte
    if (row.exp_err == SUCCESS) begin
      for (int n = 0; n < int'(row.nbytes); n++) exp_rd.push_back(row.exp_data_start + 16'(n));
      if (row.nbytes[0]) exp_rd.push_back(ZERO_LOC);
    end
    n_addr = (row.exp_target != 7'd0) ? 2 : 1;
    @(posedge sys_clk);
    cur   <= row;
    descr <= make_descr(row);
    @(posedge sys_clk);
    engine_en <= 1'b1;
    @(posedge sys_clk);
    engine_en <= 1'b0;
    cyc = 0;
    while (!engine_done && cyc < WAIT_CYCLES) begin
      @(posedge sys_clk);
      cyc++;
    end
    if (!engine_done) begin
      $display("test %0d: engine never signalled done within %0d cycles", cur_test, cyc);
      err_cnt++;
      timed_out = 1'b1;
    end else begin
      if (err_status !== row.exp_err) report_mismatch("o_err_status", 32'(err_status),
                                                      32'(row.exp_err));
      @(posedge sys_clk);
      if (engine_done || done_cnt != 1) begin
        $display("test %0d: done was not a single one cycle pulse", cur_test);
        err_cnt++;
      end
      if (bitcnt_en || tx.en) begin
        $display("test %0d: engine not back in idle after done", cur_test);
        err_cnt++;
      end
      if (odd_seen !== row.exp_odd) report_mismatch("o_engine_odd", 32'(odd_seen),
                                                    32'(row.exp_odd));
      if (last_code !== (row.exp_exit ? STALL_EXIT : STALL_RESTART))
        report_mismatch("o_stall.code", 32'(last_code), row.exp_exit ? 32'hE : 32'hF);
      if (addr_q.size() != n_addr) begin
        report_mismatch("o_txrx_addr_ccc count", 32'(addr_q.size()), 32'(n_addr));
      end else begin
        if (addr_q[0] !== 7'h7E) report_mismatch("o_txrx_addr_ccc", 32'(addr_q[0]), 32'h7E);
        if (n_addr == 2 && addr_q[1] !== row.exp_target)
          report_mismatch("o_txrx_addr_ccc", 32'(addr_q[1]), 32'(row.exp_target));
      end
      if (rd_q.size() != exp_rd.size()) begin
        report_mismatch("o_regf_addr count", 32'(rd_q.size()), 32'(exp_rd.size()));
      end else begin
        foreach (rd_q[i]) begin
          if (rd_q[i] !== exp_rd[i]) report_mismatch("o_regf_addr", 32'(rd_q[i]), 32'(exp_rd[i]));
        end
      end
    end
    if (err_cnt == errs_before) $display("test %0d cmd %h: ok", cur_test, row.cmd);
    else $display("test %0d cmd %h: %0d errors", cur_test, row.cmd, err_cnt - errs_before);
  endtask

  initial begin : main
    int cyc;
    engine_en = 1'b0;
    descr     = '0;
    //           cmd    attr  dev   dsel  toc   bytes nack  abort
    //           err        odd   exit  target  first rd  data start
    rows[0] = '{8'h00, 3'd0, 5'd0, 3'd0, 1'b1, 4'd2, 1'b0, 1'b0,   // broadcast with exit
                SUCCESS,   1'b0, 1'b1, 7'h00, 16'd999,  16'd1004};
    rows[1] = '{8'h06, 3'd0, 5'd0, 3'd1, 1'b0, 4'd3, 1'b0, 1'b0,   // defining byte and odd count
                SUCCESS,   1'b1, 1'b0, 7'h00, 16'd1002, 16'd1004};
    rows[2] = '{8'h80, 3'd0, 5'd3, 3'd0, 1'b1, 4'd2, 1'b0, 1'b0,   // direct to index 3
                SUCCESS,   1'b0, 1'b1, 7'h0B, 16'd999,  16'd1004};
    rows[3] = '{8'h08, 3'd1, 5'd0, 3'd5, 1'b1, 4'd1, 1'b0, 1'b0,   // immediate with dtt 5
                SUCCESS,   1'b1, 1'b1, 7'h00, 16'd1002, 16'd1003};
    rows[4] = '{8'h9A, 3'd1, 5'd5, 3'd2, 1'b0, 4'd2, 1'b0, 1'b0,   // immediate direct with dtt 2
                SUCCESS,   1'b0, 1'b0, 7'h0D, 16'd999,  16'd1002};
    rows[5] = '{8'h01, 3'd0, 5'd0, 3'd0, 1'b0, 4'd2, 1'b1, 1'b0,   // header NACK
                NACK,      1'b0, 1'b1, 7'h00, 16'd999,  16'd1004};
    rows[6] = '{8'h90, 3'd0, 5'd1, 3'd0, 1'b0, 4'd2, 1'b0, 1'b1,   // target frame abort
                T_ABORTED, 1'b0, 1'b1, 7'h09, 16'd999,  16'd1004};
    rows[7] = '{8'h00, 3'd0, 5'd0, 3'd1, 1'b1, 4'd4, 1'b0, 1'b1,   // broadcast data abort
                T_ABORTED, 1'b0, 1'b1, 7'h00, 16'd1002, 16'd1004};
    cyc = 0;
    while (!sys_rst && cyc < 20) begin
      @(posedge sys_clk);
      cyc++;
    end
    if (!sys_rst) begin
      $display("reset was never released");
      err_cnt++;
      timed_out = 1'b1;
    end else begin
      // nothing enabled in idle before the first start
      repeat (3) begin
        @(posedge sys_clk);
        if (|{tx.en, rx.en, stall.en, bitcnt_en, frmcnt_en, regf_rd_en, engine_done}) begin
          $display("test 0: an enable or done is high in idle after reset");
          err_cnt++;
        end
        if (err_status !== SUCCESS) report_mismatch("o_err_status", 32'(err_status), 32'h0);
      end
      if (err_cnt == 0) $display("test 0 reset: ok");
      else $display("test 0 reset: %0d errors", err_cnt);
    end
    for (int i = 0; i < NUM_ROWS && !timed_out; i++) run_row(i);
    $display("summary: %0d transfers run, %0d errors", cur_test, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+hw
hw/ccc_pkg.sv
hw/ccc_cmd_decode.sv
hw/ccc_regf_addr_gen.sv
hw/ccc_engine_fsm.sv
hw/ccc_handler.sv
tb/tb_clk_gen.sv
tb/tb_ccc_handler.sv

// File: run_sim.sh
#!/bin/sh
# build and run the CCC handler testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_ccc_handler \
  -Mdir obj_dir -o sim_ccc_handler > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build error, see build.log"
  exit 1
fi

./obj_dir/sim_ccc_handler > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  exit 0
fi
exit 1
